// File: all.f
led_pkg.sv
led_flash.sv
led_blinker.sv
led_fader.sv
led_cylon.sv
led_rate_bar.sv
led_source_select.sv
led_control.sv
tb_led_control.sv

// File: led_blinker.sv
module led_blinker #(
  parameter int unsigned blink_bits = 21
) (
  input  logic clock,
  input  logic rst_n,
  output logic fast,
  output logic slow
);

  // one extra bit on top gives the half-rate tap
  logic [blink_bits:0] div_cnt;
  logic                fast_wrap;
  logic                slow_wrap;

  // low bits about to roll over to zero
  assign fast_wrap = &div_cnt[blink_bits-1:0];
  // whole counter about to roll over, every second fast wrap
  assign slow_wrap = &div_cnt;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      fast    <= 1'b0;
      slow    <= 1'b0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
      if (fast_wrap) begin
        fast <= ~fast;
      end
      // slow heartbeat doubles as the error blink
      if (slow_wrap) begin
        slow <= ~slow;
      end
    end
  end

endmodule

// File: led_control.sv
module led_control #(
  parameter int unsigned blink_bits   = 21,
  parameter int unsigned fade_bits    = 27,
  parameter int unsigned sweep_bits   = 22,
  parameter int unsigned flash_cycles = 4_000_000,
  parameter int unsigned rate_window  = 40_000_000
) (
  input  logic                    clock,
  input  logic                    rst_n,
  input  led_pkg::link_status_t   link,
  input  led_pkg::ttc_cmd_t       ttc,
  input  led_pkg::clock_status_t  clocks,
  input  led_pkg::cluster_count_t cluster_count,
  output led_pkg::led_word_t      led_out,
  output led_pkg::rate_t          cluster_rate
);

  import led_pkg::*;

  cluster_count_t count_q;
  logic [4:0]     strobes;
  led_byte_t      flashes;
  led_byte_t      sweep;
  led_byte_t      bar;
  logic           fast;
  logic           slow;
  logic           fade;

  // input register for the cluster count
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else begin
      count_q <= cluster_count;
    end
  end

  // --------------------------------------
  // command flashes
  // --------------------------------------

  // order matches leds 12 down to 8
  assign strobes = {link.request_received, ttc.l1a, ttc.resync, ttc.bc0, ttc.vfat_reset};

  for (genvar i = 0; i < 5; i++) begin : g_flash
    led_flash #(.flash_cycles(flash_cycles)) flash_i (
      .clock  (clock),
      .rst_n  (rst_n),
      .strobe (strobes[i]),
      .flash  (flashes[i])
    );
  end

  assign flashes[7:5] = 3'b0;

  // --------------------------------------
  // pattern sources
  // --------------------------------------

  led_blinker #(.blink_bits(blink_bits)) blinker_i (
    .clock (clock),
    .rst_n (rst_n),
    .fast  (fast),
    .slow  (slow)
  );

  led_fader #(.fade_bits(fade_bits)) fader_i (
    .clock (clock),
    .rst_n (rst_n),
    .led   (fade)
  );

  led_cylon #(.sweep_bits(sweep_bits)) cylon_i (
    .clock (clock),
    .rst_n (rst_n),
    .sweep (sweep)
  );

  led_rate_bar #(.rate_window(rate_window)) rate_bar_i (
    .clock     (clock),
    .rst_n     (rst_n),
    .increment (count_q),
    .rate      (cluster_rate),
    .bar       (bar)
  );

  led_source_select select_i (
    .clock         (clock),
    .rst_n         (rst_n),
    .link          (link),
    .clocks        (clocks),
    .resync        (ttc.resync),
    .cluster_count (count_q),
    .fast          (fast),
    .slow          (slow),
    .fade          (fade),
    .flashes       (flashes),
    .sweep         (sweep),
    .bar           (bar),
    .led_out       (led_out)
  );

endmodule

// File: led_cylon.sv
module led_cylon #(
  parameter int unsigned sweep_bits = 22
) (
  input  logic               clock,
  input  logic               rst_n,
  output led_pkg::led_byte_t sweep
);

  import led_pkg::*;

  logic [sweep_bits-1:0] prescale;
  logic                  step;
  sweep_dir_t            dir;

  // one move per prescaler wrap
  assign step = &prescale;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      prescale <= '0;
      sweep    <= 8'h01;
      dir      <= sweep_left;
    end else begin
      prescale <= prescale + 1'b1;
      if (step) begin
        case (dir)
          sweep_left: begin
            // bounce off bit 7
            if (sweep[7]) begin
              sweep <= sweep >> 1;
              dir   <= sweep_right;
            end else begin
              sweep <= sweep << 1;
            end
          end
          sweep_right: begin
            // bounce off bit 0
            if (sweep[0]) begin
              sweep <= sweep << 1;
              dir   <= sweep_left;
            end else begin
              sweep <= sweep >> 1;
            end
          end
          default: dir <= sweep_left;
        endcase
      end
    end
  end

endmodule

// File: led_fader.sv
module led_fader #(
  parameter int unsigned fade_bits = 27
) (
  input  logic clock,
  input  logic rst_n,
  output logic led
);

  import led_pkg::*;

  // pwm phase in the low half, one brightness step per ramp counter wrap
  localparam int unsigned pwm_bits  = fade_bits / 2;
  localparam int unsigned step_bits = fade_bits - pwm_bits;

  logic [step_bits-1:0] ramp_cnt;
  logic [pwm_bits-1:0]  duty;
  logic                 step;
  fade_dir_t            dir;

  // brightness moves one level each time the ramp counter rolls over
  assign step = &ramp_cnt;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      ramp_cnt <= '0;
      duty     <= '0;
      dir      <= fade_up;
      led      <= 1'b0;
    end else begin
      ramp_cnt <= ramp_cnt + 1'b1;

      // pwm compare, registered so the output has no glitches
      led <= (ramp_cnt[pwm_bits-1:0] < duty);

      if (step) begin
        case (dir)
          fade_up: begin
            // hold at full brightness for one step, then turn
            if (&duty) begin
              dir <= fade_down;
            end else begin
              duty <= duty + 1'b1;
            end
          end
          fade_down: begin
            if (duty == '0) begin
              dir <= fade_up;
            end else begin
              duty <= duty - 1'b1;
            end
          end
          default: dir <= fade_up;
        endcase
      end
    end
  end

endmodule

// File: led_flash.sv
module led_flash #(
  parameter int unsigned flash_cycles = 4_000_000
) (
  input  logic clock,
  input  logic rst_n,
  input  logic strobe,
  output logic flash
);

  // wide enough to hold flash_cycles itself
  localparam int unsigned cnt_bits = $clog2(flash_cycles + 1);

  logic [cnt_bits-1:0] remaining;

  // reload on every strobe, so a strobe during a flash restarts it
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      remaining <= '0;
    end else if (strobe) begin
      remaining <= cnt_bits'(flash_cycles);
    end else if (remaining != '0) begin
      remaining <= remaining - 1'b1;
    end
  end

  // lit for exactly flash_cycles edges after the strobe
  assign flash = (remaining != '0);

endmodule

// File: led_pkg.sv
package led_pkg;

  // --------------------------------------
  // vector types
  // --------------------------------------

  // whole front panel
  typedef logic [15:0] led_word_t;

  // half panel: bar, sweep or error field
  typedef logic [7:0] led_byte_t;

  // clusters reported in a single clock cycle
  typedef logic [7:0] cluster_count_t;

  // clusters summed over one rate window
  typedef logic [31:0] rate_t;

  // --------------------------------------
  // status groups
  // --------------------------------------

  typedef struct packed {
    logic rxready;
    logic rxvalid;
    logic link_ready;
    logic request_received;  // single-cycle strobe
  } link_status_t;

  // all four are single-cycle strobes
  typedef struct packed {
    logic l1a;
    logic bc0;
    logic resync;
    logic vfat_reset;
  } ttc_cmd_t;

  typedef struct packed {
    logic mmcm_locked;
    logic elink_locked;
    logic logic_locked;
  } clock_status_t;

  // --------------------------------------
  // state encodings
  // --------------------------------------

  typedef enum logic {fade_up, fade_down} fade_dir_t;

  typedef enum logic {sweep_left, sweep_right} sweep_dir_t;

endpackage

// File: led_rate_bar.sv
module led_rate_bar #(
  parameter int unsigned rate_window = 40_000_000
) (
  input  logic                   clock,
  input  logic                   rst_n,
  input  led_pkg::cluster_count_t increment,
  output led_pkg::rate_t          rate,
  output led_pkg::led_byte_t      bar
);

  import led_pkg::*;

  localparam int unsigned win_bits = $clog2(rate_window);

  logic [win_bits-1:0] win_cnt;
  logic                win_last;
  rate_t               acc;
  rate_t               sum;

  // position of the highest set bit, plus one
  function automatic logic [5:0] bit_length(input rate_t value);
    logic [5:0] n;
    n = '0;
    for (int i = 0; i < 32; i++) begin
      if (value[i]) begin
        n = 6'(i + 1);
      end
    end
    return n;
  endfunction

  // lowest n leds lit, saturating at the full byte
  function automatic led_byte_t log_bar(input rate_t value);
    logic [5:0] n;
    n = bit_length(value);
    if (n >= 6'd8) begin
      return 8'hFF;
    end
    return led_byte_t'((9'd1 << n) - 9'd1);
  endfunction

  assign win_last = (win_cnt == win_bits'(rate_window - 1));

  // the count arriving on the last cycle still belongs to this window
  assign sum = acc + rate_t'(increment);

  // --------------------------------------
  // window accumulate and publish
  // --------------------------------------

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      win_cnt <= '0;
      acc     <= '0;
      rate    <= '0;
      bar     <= '0;
    end else if (win_last) begin
      win_cnt <= '0;
      acc     <= '0;
      // rate and bar move together and hold for the next window
      rate    <= sum;
      bar     <= log_bar(sum);
    end else begin
      win_cnt <= win_cnt + 1'b1;
      acc     <= sum;
    end
  end

endmodule

// File: led_source_select.sv
module led_source_select (
  input  logic                   clock,
  input  logic                   rst_n,
  input  led_pkg::link_status_t  link,
  input  led_pkg::clock_status_t clocks,
  input  logic                   resync,
  input  led_pkg::cluster_count_t cluster_count,
  input  logic                   fast,
  input  logic                   slow,
  input  logic                   fade,
  input  led_pkg::led_byte_t      flashes,
  input  led_pkg::led_byte_t      sweep,
  input  led_pkg::led_byte_t      bar,
  output led_pkg::led_word_t      led_out
);

  import led_pkg::*;

  logic      cluster_seen;
  led_byte_t high_byte;
  led_byte_t low_byte;
  led_byte_t err_byte;

  // --------------------------------------
  // cluster-seen flag
  // --------------------------------------

  // resync wins, so the sweep comes back for each new run
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      cluster_seen <= 1'b0;
    end else if (resync) begin
      cluster_seen <= 1'b0;
    end else if (cluster_count != '0) begin
      cluster_seen <= 1'b1;
    end
  end

  // --------------------------------------
  // panel mux
  // --------------------------------------

  // flashes arrive already placed in bits 4..0, upper bits zero
  assign high_byte = {slow, fast, link.link_ready & fade, 5'b0} | flashes;

  // blinking field with the two secondary locks laid over it
  assign err_byte = {8{slow}} | {{4{clocks.elink_locked}}, {4{clocks.logic_locked}}};

  always_comb begin
    if (!link.rxready || !link.rxvalid) begin
      low_byte = {8{fade}};
    end else if (!clocks.mmcm_locked) begin
      low_byte = err_byte;
    end else if (!cluster_seen) begin
      low_byte = sweep;
    end else begin
      low_byte = bar;
    end
  end

  assign led_out = {high_byte, low_byte};

endmodule

// File: tb_led_control.sv
module tb_led_control;

  import led_pkg::*;

  localparam int unsigned flash_len = 5;
  localparam int unsigned window    = 64;

  logic           clock;
  logic           rst_n;
  link_status_t   link;
  ttc_cmd_t       ttc;
  clock_status_t  clocks;
  cluster_count_t cluster_count;
  led_word_t      led_out;
  rate_t          cluster_rate;

  // edges since reset release, sampled at the falling edge
  int          cyc;
  int          error_count;
  int          check_count;
  int          tests_passed;
  int          test_errors;
  logic [31:0] lfsr;

  // published rate expectations, edge number and sum
  int    exp_edge[$];
  rate_t exp_sum[$];

  led_control #(
    .blink_bits   (4),
    .fade_bits    (6),
    .sweep_bits   (2),
    .flash_cycles (flash_len),
    .rate_window  (window)
  ) dut_i (
    .clock         (clock),
    .rst_n         (rst_n),
    .link          (link),
    .ttc           (ttc),
    .clocks        (clocks),
    .cluster_count (cluster_count),
    .led_out       (led_out),
    .cluster_rate  (cluster_rate)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  // ----------------------------------------
  // reference model
  // ----------------------------------------

  // taps 32 22 2 1
  function automatic logic [31:0] next_lfsr(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // lowest n bits lit, n = bit length of the rate, at most 8
  function automatic led_byte_t expected_bar(input rate_t rate);
    rate_t v;
    int    n;
    v = rate;
    n = 0;
    while (v != 0) begin
      v = v >> 1;
      n++;
    end
    if (n > 8) begin
      n = 8;
    end
    return led_byte_t'((1 << n) - 1);
  endfunction

  // fast toggles on every 16th edge, slow on every 32nd
  function automatic logic fast_expected(input int edges);
    return logic'((edges / 16) % 2);
  endfunction

  function automatic logic slow_expected(input int edges);
    return logic'((edges / 32) % 2);
  endfunction

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  task automatic finish_run(input logic ok);
    if (ok) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  // inputs change a short delay after the rising edge
  task automatic after_edge();
    @(posedge clock);
    #10;
  endtask

  // one lfsr step per bit taken
  task automatic random_bits(input int n, output logic [31:0] value);
    value = '0;
    repeat (n) begin
      lfsr  = next_lfsr(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  // src is the led bit minus 8
  task automatic set_strobe(input int src, input logic value);
    case (src)
      0: ttc.vfat_reset = value;
      1: ttc.bc0 = value;
      2: ttc.resync = value;
      3: ttc.l1a = value;
      default: link.request_received = value;
    endcase
  endtask

  task automatic close_test(input int id, input string name);
    if (error_count == test_errors) begin
      tests_passed++;
      $display("[%0d] %s: ok", id, name);
    end else begin
      $display("[%0d] %s: %0d errors", id, name, error_count - test_errors);
    end
    test_errors = error_count;
  endtask

  task automatic wait_window_start();
    int n;
    n = 0;
    while (cyc % window != 0) begin
      if (n > 2 * window) begin
        $display("timeout: no rate window boundary seen");
        finish_run(1'b0);
      end
      after_edge();
      n++;
    end
  endtask

  // drains once the compare process has seen every published rate
  task automatic wait_rate_checks();
    int n;
    n = 0;
    while (exp_edge.size() != 0) begin
      if (n > 3 * window) begin
        $display("timeout: cluster_rate was never published");
        finish_run(1'b0);
      end
      after_edge();
      n++;
    end
  endtask

  // compare process for published rate and bar
  always @(negedge clock) begin
    if (exp_edge.size() != 0 && cyc == exp_edge[0]) begin
      check_value("cluster_rate", cluster_rate, exp_sum[0]);
      check_value("led_out[7:0]", led_out[7:0], expected_bar(exp_sum[0]));
      void'(exp_edge.pop_front());
      void'(exp_sum.pop_front());
    end
  end

  // ----------------------------------------
  // tests
  // ----------------------------------------

  task automatic link_down();
    repeat (60) begin
      @(negedge clock);
      check_value("led_out[7:0] all equal", led_out[7:0] == 8'h00 || led_out[7:0] == 8'hFF, 1);
      check_value("led_out[13]", led_out[13], 0);
    end
  endtask

  // gap > 1 retriggers the strobe gap edges after the first one
  task automatic watch_flash(input int src, input int gap);
    string name;
    name = $sformatf("led_out[%0d]", 8 + src);
    after_edge();
    set_strobe(src, 1'b1);
    after_edge();
    set_strobe(src, 1'b0);
    for (int j = 0; j < flash_len + gap + 3; j++) begin
      @(negedge clock);
      check_value(name, led_out[8 + src], j < flash_len + gap);
      after_edge();
      set_strobe(src, gap > 0 && j == gap - 2);
    end
  endtask

  task automatic flashes_and_heartbeat();
    for (int src = 0; src < 5; src++) begin
      watch_flash(src, 0);
    end
    watch_flash(3, 2);
    watch_flash(4, 3);
    repeat (80) begin
      @(negedge clock);
      check_value("led_out[14]", led_out[14], fast_expected(cyc));
      check_value("led_out[15]", led_out[15], slow_expected(cyc));
    end
  endtask

  task automatic clock_unlocked();
    after_edge();
    link.rxready    = 1'b1;
    link.rxvalid    = 1'b1;
    link.link_ready = 1'b1;
    clocks          = 3'b011;
    repeat (40) begin
      @(negedge clock);
      check_value("led_out[7:0]", led_out[7:0], 8'hFF);
    end
    after_edge();
    clocks.logic_locked = 1'b0;
    // 70 cycles covers both phases of the slow blink
    repeat (70) begin
      @(negedge clock);
      check_value("led_out[7:0]", led_out[7:0], {4'hF, {4{slow_expected(cyc)}}});
    end
  endtask

  task automatic sweep_pattern();
    int pos;
    int prev;
    int dir;
    int moves;
    after_edge();
    clocks = 3'b111;
    prev   = -1;
    dir    = 0;
    moves  = 0;
    repeat (120) begin
      @(negedge clock);
      check_value("led_out[7:0] one-hot", $onehot(led_out[7:0]), 1);
      pos = 0;
      for (int i = 0; i < 8; i++) begin
        if (led_out[i]) begin
          pos = i;
        end
      end
      if (prev >= 0 && pos != prev) begin
        // bounce at both ends, otherwise keep going the same way
        if (prev == 7) begin
          check_value("sweep position", pos, 6);
        end else if (prev == 0) begin
          check_value("sweep position", pos, 1);
        end else if (dir != 0) begin
          check_value("sweep position", pos, prev + dir);
        end else begin
          check_value("sweep step size", pos == prev + 1 || pos == prev - 1, 1);
        end
        dir = pos - prev;
        moves++;
      end
      prev = pos;
    end
    if (moves < 20) begin
      error_count++;
      $display("sweep moved only %0d times in 120 cycles", moves);
    end
  endtask

  task automatic rate_windows();
    int          widths[4] = '{1, 3, 5, 8};
    int          start;
    logic [31:0] pick;
    logic [31:0] value;
    rate_t       sum;
    after_edge();
    for (int win = 0; win < 4; win++) begin
      wait_window_start();
      start = cyc;
      sum   = '0;
      // value for t is seen by the top on edge start+t
      for (int t = 1; t <= window; t++) begin
        value = '0;
        if (t >= 8 && t <= window - 8) begin
          random_bits(2, pick);
          if (pick == 3 || t == window / 2) begin
            random_bits(widths[win], value);
            if (value == 0) begin
              value = 1;
            end
          end
        end
        cluster_count = cluster_count_t'(value);
        sum           = sum + value;
        if (t < window) begin
          after_edge();
        end
      end
      exp_sum.push_back(sum);
      exp_edge.push_back(start + window);
      after_edge();
      cluster_count = '0;
    end
    wait_rate_checks();
  endtask

  task automatic resync_restart();
    int start;
    after_edge();
    ttc.resync = 1'b1;
    after_edge();
    ttc.resync = 1'b0;
    repeat (40) begin
      @(negedge clock);
      check_value("led_out[7:0] one-hot", $onehot(led_out[7:0]), 1);
      after_edge();
    end
    // previous window was all zeros, so the bar is dark
    wait_window_start();
    start = cyc;
    for (int t = 1; t <= 12; t++) begin
      after_edge();
      cluster_count = (t == 9) ? 8'd3 : 8'd0;
      @(negedge clock);
      if (t <= 10) begin
        check_value("led_out[7:0] one-hot", $onehot(led_out[7:0]), 1);
      end else begin
        check_value("led_out[7:0]", led_out[7:0], expected_bar(0));
      end
    end
    exp_sum.push_back(3);
    exp_edge.push_back(start + window);
    wait_rate_checks();
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    rst_n         = 1'b0;
    link          = '0;
    ttc           = '0;
    clocks        = '0;
    cluster_count = '0;
    lfsr          = 32'h3bb3;
    error_count   = 0;
    check_count   = 0;
    tests_passed  = 0;
    test_errors   = 0;
    repeat (16) @(posedge clock);
    #10;
    rst_n = 1'b1;
    link_down();
    close_test(1, "link down");
    flashes_and_heartbeat();
    close_test(2, "flashes and heartbeat");
    clock_unlocked();
    close_test(3, "clock unlocked");
    sweep_pattern();
    close_test(4, "sweep");
    rate_windows();
    close_test(5, "rate");
    resync_restart();
    close_test(6, "resync");
    $display("tests: 6, passed: %0d, checks: %0d, errors: %0d",
             tests_passed, check_count, error_count);
    finish_run(error_count == 0);
  end

endmodule
